// File: usb_sniffer_uart.f
+incdir+logic
logic/sniffer_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/echo_queue.sv
logic/test_clk_div.sv
logic/sniffer_top.sv
testbench/sniffer_chk.sv
testbench/tb_sniffer.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run, the result is taken from the simulation log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -f usb_sniffer_uart.f \
    --top-module tb_sniffer -Mdir obj_dir -o tb_sniffer_sim > build.log 2>&1 &&
obj_dir/tb_sniffer_sim > sim.log 2>&1
grep -q "TB PASSED" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: testbench/tb_sniffer.sv
// Testbench with serial driver and monitor, queue and divider models, compare tasks, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "sniffer_config.svh"

module tb_sniffer import sniffer_pkg::*; ();

    localparam int CPB        = `SNF_CLKS_PER_BIT;
    localparam int FRAME_CYC  = 10 * CPB;      // Start, data, stop
    localparam int DEPTH      = `SNF_QUEUE_DEPTH;
    localparam int N_GOOD     = 24;            // Wide-gap phase
    localparam int N_BURST    = 150;           // Enough to outrun a 161-cycle echo
    localparam int BURST_STOP = 12;            // Short stop bit since rx rearms at stop center
    localparam int CLK_NS     = 40;
    localparam longint WATCHDOG_NS =
        longint'(N_GOOD + N_BURST) * 12 * FRAME_CYC * CLK_NS + 200_000;

    typedef struct packed {
        uart_byte_t data;
        logic       bad;   // Stop bit driven low
    } frame_rec_t;

    logic            clk_test;
    logic            rst;
    logic            uart_rx;
    logic            div_enable;
    logic            uart_tx;
    sniffer_status_t status;
    uart_byte_t      rx_last;
    logic            test_clk;
    logic            test_pulse;

    frame_rec_t  sent_q[$];   // On the wire and waiting for nrd
    uart_byte_t  model_q[$];  // Echo queue model
    uart_byte_t  echo_q[$];   // Handed to the transmitter and waiting for the monitor
    int          tx_busy;     // Model tip cycles left
    logic        model_ovf;
    int          drops;
    logic [31:0] stim_seed;
    logic [31:0] div_seed;

    sniffer_top u_dut (
        .clk_test   (clk_test),
        .rst        (rst),
        .uart_rx    (uart_rx),
        .div_enable (div_enable),
        .uart_tx    (uart_tx),
        .status     (status),
        .rx_last    (rx_last),
        .test_clk   (test_clk),
        .test_pulse (test_pulse)
    );

    initial begin
        clk_test = 1'b0;
        forever #(CLK_NS / 2) clk_test = ~clk_test;
    end

    // 32-bit LCG step
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %02h, expected %02h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_status(input sniffer_status_t got, input sniffer_status_t exp,
                                input string what);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s tip/nrd/ferr/ovf is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // One 8N1 frame driven from a falling edge
    task automatic send_frame(input uart_byte_t data, input logic bad, input int stop_cyc);
        frame_rec_t rec;
        rec.data = data;
        rec.bad  = bad;
        sent_q.push_back(rec);
        uart_rx = 1'b0;
        repeat (CPB) @(negedge clk_test);
        for (int k = 0; k < `SNF_DATA_BITS; k++) begin
            uart_rx = data[k]; // LSB first
            repeat (CPB) @(negedge clk_test);
        end
        uart_rx = !bad;
        repeat (stop_cyc) @(negedge clk_test);
        uart_rx = 1'b1;
    endtask

    // Per-cycle model of queue and transmitter occupancy
    task automatic model_cycle();
        frame_rec_t      rec;
        sniffer_status_t exp_st;
        logic            tip_now;
        logic            do_send;
        logic            push;
        tip_now = (tx_busy != 0);
        do_send = (model_q.size() != 0) && !tip_now;
        push    = 1'b0;
        rec     = '0;
        check_level(status.tip, tip_now, "status.tip");
        check_level(status.overflow, model_ovf, "status.overflow");
        if (status.nrd) begin
            if (sent_q.size() == 0) stop_run("nrd pulse seen with no frame sent on uart_rx");
            rec    = sent_q.pop_front();
            exp_st = '{tip: tip_now, nrd: 1'b1, frame_err: rec.bad, overflow: model_ovf};
            check_byte(rx_last, rec.data, "rx_last at nrd");
            check_status(status, exp_st, "status at nrd");
            push = !rec.bad; // Bad stop never echoed
        end
        if (do_send) echo_q.push_back(model_q.pop_front()); // Pop frees a slot first
        if (push) begin
            if (model_q.size() < DEPTH) begin
                model_q.push_back(rec.data);
            end else begin
                model_ovf = 1'b1;
                drops++;
            end
        end
        if (do_send) tx_busy = FRAME_CYC; // tip from next cycle on
        else if (tx_busy != 0) tx_busy--;
    endtask

    // Decodes uart_tx at bit centers on falling edges
    task automatic monitor_tx();
        uart_byte_t got;
        uart_byte_t exp;
        got = '0;
        forever begin
            @(negedge clk_test);
            if (uart_tx == 1'b0) begin
                repeat (CPB / 2 - 1) @(negedge clk_test); // Start center
                if (uart_tx !== 1'b0) stop_run("start bit on uart_tx did not last to its center");
                for (int k = 0; k < `SNF_DATA_BITS; k++) begin
                    repeat (CPB) @(negedge clk_test);
                    got[k] = uart_tx;
                end
                repeat (CPB) @(negedge clk_test);
                if (uart_tx !== 1'b1) stop_run("stop bit on uart_tx was not high");
                if (echo_q.size() == 0) stop_run("echo frame on uart_tx with none expected");
                exp = echo_q.pop_front();
                check_byte(got, exp, "echo byte");
            end
        end
    endtask

    // Button pattern and divider model with enable drawn for the next rising edge
    task automatic run_divider_model();
        logic exp_clk;
        logic exp_pulse;
        logic en;
        int   cnt;
        int   run_left;
        exp_clk  = 1'b0;
        exp_pulse = 1'b0;
        en       = 1'b0;
        cnt      = 0;
        run_left = 0;
        forever begin
            if (run_left == 0) begin
                div_seed = lcg_step(div_seed);
                en       = (div_seed[31:30] != 2'b00); // Mostly pressed
                run_left = 1 + int'(div_seed[21:16]);
            end
            run_left--;
            div_enable = en;
            exp_pulse  = 1'b0;
            if (en) begin
                if (cnt == `SNF_TEST_DIV - 1) begin
                    cnt       = 0;
                    exp_clk   = !exp_clk;
                    exp_pulse = exp_clk; // Only when the toggle went high
                end else begin
                    cnt++;
                end
            end
            @(negedge clk_test);
            check_level(test_clk, exp_clk, "test_clk");
            check_level(test_pulse, exp_pulse, "test_pulse");
        end
    endtask

    initial begin
        sniffer_status_t exp_st;
        logic            bad;
        uart_rx    = 1'b1;
        div_enable = 1'b0;
        rst        = 1'b1;
        stim_seed  = 32'd320;
        div_seed   = lcg_step(32'd320 + 32'd1); // Separate stream for the button
        tx_busy    = 0;
        model_ovf  = 1'b0;
        drops      = 0;
        repeat (8) @(negedge clk_test);
        rst = 1'b0;
        check_level(uart_tx, 1'b1, "uart_tx after reset");
        check_status(status, '0, "status after reset");
        fork
            forever begin
                @(negedge clk_test);
                model_cycle();
            end
            monitor_tx();
            run_divider_model();
        join_none

        // Isolated frames with occasional bad stop bits
        for (int i = 0; i < N_GOOD; i++) begin
            stim_seed = lcg_step(stim_seed);
            bad       = (i == 5) || (stim_seed[31:29] == 3'b000);
            send_frame(stim_seed[15:8], bad, CPB);
            stim_seed = lcg_step(stim_seed);
            repeat (FRAME_CYC + int'(stim_seed[23:16])) @(negedge clk_test);
        end

        // Back-to-back burst drifting ahead of the echo until the queue fills
        for (int i = 0; i < N_BURST; i++) begin
            stim_seed = lcg_step(stim_seed);
            send_frame(stim_seed[15:8], 1'b0, BURST_STOP);
        end

        while (sent_q.size() != 0 || model_q.size() != 0 || echo_q.size() != 0 ||
               tx_busy != 0) begin
            @(negedge clk_test);
        end
        repeat (CPB) @(negedge clk_test);
        if (model_ovf) begin
            exp_st = '{tip: 1'b0, nrd: 1'b0, frame_err: 1'b0, overflow: 1'b1};
            check_status(status, exp_st, "final status");
            check_level(uart_tx, 1'b1, "uart_tx at end");
            $display("%0d frames sent, %0d dropped by the queue", N_GOOD + N_BURST, drops);
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("burst ended without overflowing the echo queue");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("timeout: the run did not finish within the watchdog limit");
    end

endmodule

`default_nettype wire

// File: testbench/sniffer_chk.sv
// Bound assertions for idle line level, send against busy transmitter, nrd width, sticky overflow
`timescale 1ns/1ps
`default_nettype none

module sniffer_chk import sniffer_pkg::*; (
    input logic            clk_test,
    input logic            rst,
    input logic            uart_tx,
    input logic            send,    // Queue to transmitter strobe
    input sniffer_status_t status
);

    // Mark level whenever nothing is being sent
    idle_line_high: assert property (@(posedge clk_test) disable iff (rst)
        !status.tip |-> uart_tx)
        else $error("uart_tx low while no transmit is in progress");

    send_not_busy: assert property (@(posedge clk_test) disable iff (rst)
        !(send && status.tip))
        else $error("send issued while the transmitter was busy");

    // Strobe, never a level
    nrd_one_cycle: assert property (@(posedge clk_test) disable iff (rst)
        status.nrd |=> !status.nrd)
        else $error("nrd held high for more than one cycle");

    overflow_sticky: assert property (@(posedge clk_test) disable iff (rst)
        status.overflow |=> status.overflow)
        else $error("overflow cleared without reset");

endmodule

bind sniffer_top sniffer_chk u_chk (
    .clk_test (clk_test),
    .rst      (rst),
    .uart_tx  (uart_tx),
    .send     (send),
    .status   (status)
);

`default_nettype wire

// File: logic/sniffer_top.sv
// Sniffer serial top with receiver, echo queue, transmitter, test divider and status assembly
`timescale 1ns/1ps
`default_nettype none

module sniffer_top import sniffer_pkg::*; (
    input  logic            clk_test,
    input  logic            rst,
    input  logic            uart_rx,    // Serial in from host
    input  logic            div_enable,
    output logic            uart_tx,    // Serial out to host
    output sniffer_status_t status,
    output uart_byte_t      rx_last,
    output logic            test_clk,
    output logic            test_pulse
);

    rx_result_t rx_res;
    logic       send;
    logic       tip;
    logic       overflow;
    uart_byte_t tx_byte;

    // Receive side
    uart_rx u_rx (
        .clk_test (clk_test),
        .rst      (rst),
        .line     (uart_rx),
        .result   (rx_res)
    );

    // Buffers good bytes while the transmitter is busy
    echo_queue u_queue (
        .clk_test (clk_test),
        .rst      (rst),
        .rx_in    (rx_res),
        .tip      (tip),
        .send     (send),
        .tx_byte  (tx_byte),
        .overflow (overflow)
    );

    // Echo side
    uart_tx u_tx (
        .clk_test (clk_test),
        .rst      (rst),
        .send     (send),
        .data     (tx_byte),
        .line     (uart_tx),
        .tip      (tip)
    );

    // Independent visible clock
    test_clk_div u_div (
        .clk_test   (clk_test),
        .rst        (rst),
        .enable     (div_enable),
        .test_clk   (test_clk),
        .test_pulse (test_pulse)
    );

    assign rx_last = rx_res.data;
    assign status  = '{tip:       tip,
                       nrd:       rx_res.nrd,
                       frame_err: rx_res.frame_err,
                       overflow:  overflow};

endmodule

`default_nettype wire

// File: logic/test_clk_div.sv
// Enable-gated divider for the slow test clock and its rising-edge pulse
`timescale 1ns/1ps
`default_nettype none

`include "sniffer_config.svh"

module test_clk_div (
    input  logic clk_test,
    input  logic rst,
    input  logic enable,     // Button level
    output logic test_clk,
    output logic test_pulse
);

    localparam int CNT_W = $clog2(`SNF_TEST_DIV);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_W'(`SNF_TEST_DIV - 1));

    always_ff @(posedge clk_test) begin
        if (rst) begin
            cnt        <= '0;
            test_clk   <= 1'b0;
            test_pulse <= 1'b0;
        end else begin
            // Pulse marks the low-to-high toggle only
            test_pulse <= enable && wrap && !test_clk;
            if (enable) begin
                if (wrap) begin
                    cnt      <= '0;
                    test_clk <= ~test_clk;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end // Count and clock frozen otherwise
        end
    end

endmodule

`default_nettype wire

// File: logic/echo_queue.sv
// Circular echo byte queue with send issue logic and sticky overflow flag
`timescale 1ns/1ps
`default_nettype none

`include "sniffer_config.svh"

module echo_queue import sniffer_pkg::*; (
    input  logic       clk_test,
    input  logic       rst,
    input  rx_result_t rx_in,
    input  logic       tip,      // Transmitter busy
    output logic       send,
    output uart_byte_t tx_byte,
    output logic       overflow
);

    localparam int DEPTH = `SNF_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    uart_byte_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;   // Good byte offered
    logic             accept; // Byte actually stored

    assign full    = (count == CNT_W'(DEPTH));
    assign push    = rx_in.nrd && !rx_in.frame_err;
    assign send    = (count != '0) && !tip; // Pop and issue in one cycle
    assign accept  = push && (!full || send); // Slot freed by same-cycle pop
    assign tx_byte = mem[rd_ptr];

    always_ff @(posedge clk_test) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (accept) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (send)   rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({accept, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
            if (push && !accept) overflow <= 1'b1; // Cleared only by rst
        end
    end

    // Storage
    always_ff @(posedge clk_test) begin
        if (accept) mem[wr_ptr] <= rx_in.data;
    end

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
// 8N1 UART receiver with input synchronizer, start glitch filter and framing check
`timescale 1ns/1ps
`default_nettype none

`include "sniffer_config.svh"

module uart_rx import sniffer_pkg::*; (
    input  logic       clk_test,
    input  logic       rst,
    input  logic       line,   // Asynchronous serial input
    output rx_result_t result
);

    localparam int CNT_W = $clog2(`SNF_CLKS_PER_BIT);
    localparam int BIT_W = $clog2(`SNF_DATA_BITS);
    localparam int HALF  = `SNF_CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t  state;
    logic       sync_1;    // Metastability stage
    logic       sync_2;    // Safe to use
    logic       line_prev; // For edge detect
    logic       fall;
    logic       half_hit;
    logic       full_hit;
    logic [CNT_W-1:0] cyc_cnt;
    logic [BIT_W-1:0] bit_cnt;
    uart_byte_t shift_reg;
    uart_byte_t data_q;
    logic       nrd_q;
    logic       err_q;

    assign fall     = line_prev && !sync_2;
    assign half_hit = (cyc_cnt == CNT_W'(HALF - 1));
    assign full_hit = (cyc_cnt == CNT_W'(`SNF_CLKS_PER_BIT - 1));

    // Two-flop synchronizer plus one history stage, idle high
    always_ff @(posedge clk_test) begin
        if (rst) begin
            sync_1    <= 1'b1;
            sync_2    <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_1    <= line;
            sync_2    <= sync_1;
            line_prev <= sync_2;
        end
    end

    // Frame FSM
    always_ff @(posedge clk_test) begin
        if (rst) begin
            state   <= ST_IDLE;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            nrd_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            nrd_q <= 1'b0; // Strobe by default
            case (state)
                ST_IDLE: begin
                    cyc_cnt <= '0;
                    if (fall) state <= ST_START;
                end
                ST_START: begin
                    if (half_hit) begin
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        // High at start center means a glitch
                        state   <= sync_2 ? ST_IDLE : ST_DATA;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (full_hit) begin
                        cyc_cnt <= '0;
                        if (bit_cnt == BIT_W'(`SNF_DATA_BITS - 1)) state <= ST_STOP;
                        else bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (full_hit) begin
                        nrd_q <= 1'b1;
                        err_q <= !sync_2; // Stop must be high
                        state <= ST_IDLE; // Rearmed for next edge
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk_test) begin
        if (state == ST_DATA && full_hit) shift_reg <= {sync_2, shift_reg[`SNF_DATA_BITS-1:1]};
        if (state == ST_STOP && full_hit) data_q <= shift_reg; // Held until next frame
    end

    assign result = '{data: data_q, nrd: nrd_q, frame_err: err_q};

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
// 8N1 UART transmitter with shift frame, bit timer and transmit-in-progress flag
`timescale 1ns/1ps
`default_nettype none

`include "sniffer_config.svh"

module uart_tx import sniffer_pkg::*; (
    input  logic       clk_test,
    input  logic       rst,
    input  logic       send,  // One-cycle strobe, honoured only when idle
    input  uart_byte_t data,
    output logic       line,
    output logic       tip
);

    localparam int CNT_W      = $clog2(`SNF_CLKS_PER_BIT);
    localparam int FRAME_BITS = `SNF_DATA_BITS + 2; // Start + data + stop
    localparam int IDX_W      = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] frame;   // Bit 0 is on the line
    logic [CNT_W-1:0]      cyc_cnt; // Cycles within current bit
    logic [IDX_W-1:0]      bit_idx; // Which frame bit is out
    logic                  bit_end;
    logic                  start;

    assign bit_end = (cyc_cnt == CNT_W'(`SNF_CLKS_PER_BIT - 1));
    assign start   = send && !tip;

    // Control path
    always_ff @(posedge clk_test) begin
        if (rst) begin
            tip     <= 1'b0;
            cyc_cnt <= '0;
            bit_idx <= '0;
        end else if (!tip) begin
            if (send) begin
                tip     <= 1'b1; // Start bit goes out next cycle
                cyc_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            cyc_cnt <= '0;
            if (bit_idx == IDX_W'(FRAME_BITS - 1)) begin
                tip <= 1'b0; // Stop bit done
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // Frame shifter, stop bit high and start bit low
    always_ff @(posedge clk_test) begin
        if (start) begin
            frame <= {1'b1, data, 1'b0};
        end else if (tip && bit_end) begin
            frame <= {1'b1, frame[FRAME_BITS-1:1]}; // Fill with idle level
        end
    end

    // Line rests high between frames
    assign line = tip ? frame[0] : 1'b1;

endmodule

`default_nettype wire

// File: logic/sniffer_pkg.sv
// Shared types for the serial side: data byte, receiver result and status word
`default_nettype none

`include "sniffer_config.svh"

package sniffer_pkg;

    // One serial payload word
    typedef logic [`SNF_DATA_BITS-1:0] uart_byte_t;

    // Receiver output bundle
    typedef struct packed {
        uart_byte_t data;      // Last complete byte
        logic       nrd;       // New data ready, one cycle
        logic       frame_err; // Stop bit read low
    } rx_result_t;

    // Status word seen at the top level
    typedef struct packed {
        logic tip;       // Transmit in progress
        logic nrd;       // Mirror of receiver strobe
        logic frame_err; // Last frame had a bad stop bit
        logic overflow;  // Sticky, set on dropped byte
    } sniffer_status_t;

endpackage

`default_nettype wire

// File: logic/sniffer_config.svh
// Build-time constants for serial timing, frame size, test divider and echo queue depth
`ifndef SNIFFER_CONFIG_SVH
`define SNIFFER_CONFIG_SVH

// Serial bit time in clk_test cycles
// Kept small for simulation, scale up for a real baud rate
`define SNF_CLKS_PER_BIT 16

// Payload bits in one 8N1 frame
`define SNF_DATA_BITS 8

// Half period of the visible test clock, in cycles
`define SNF_TEST_DIV 19

// Bytes buffered between receiver and transmitter
`define SNF_QUEUE_DEPTH 4

`endif
